//--- files.f
+incdir+.
pix_data_pkg.sv
pix_ctrl_pkg.sv
sync_fifo.sv
frame_mem_ctrl.sv
frame_capture.sv
pix_controller.sv
tb_clk_gen.sv
pix_checker.sv
tb_pix_controller.sv

//--- tb_pix_controller.sv
`include "pix_cfg.svh"

module tb_pix_controller
    import pix_data_pkg::*;
    import pix_ctrl_pkg::*;
();
    localparam int TIMEOUT = 5000;

    logic                       clk;
    logic                       fifoIn_rst;
    logic                       restart;
    pix_cmd_t                   cmd;
    logic [`PIX_BLOCK_BITS-1:0] cmd_block;
    pix_in_t                    pix;
    pix_status_t                status;
    logic                       readout_ready;
    logic                       readout_trigger;
    mem_word_t                  readout_data;
    logic                       readout_done;

    int err_cnt;
    int capture_cnt;
    int started_cnt;
    int done_cnt;
    int word_cnt;
    int drop_cycles;
    int tb_errs;
    int tests_run;
    int tests_failed;
    int errs_before;
    int drops_before;

    tb_clk_gen u_clk (.clk(clk), .fifoIn_rst(fifoIn_rst), .restart(restart));

    pix_controller DUT (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .cmd(cmd), .cmd_block(cmd_block), .pix(pix),
        .status(status), .readout_ready(readout_ready), .readout_trigger(readout_trigger),
        .readout_data(readout_data), .readout_done(readout_done)
    );

    pix_checker u_chk (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .cmd(cmd), .cmd_block(cmd_block), .pix(pix),
        .status(status), .readout_ready(readout_ready), .readout_trigger(readout_trigger),
        .readout_data(readout_data), .readout_done(readout_done), .err_cnt(err_cnt),
        .capture_cnt(capture_cnt), .started_cnt(started_cnt), .done_cnt(done_cnt),
        .word_cnt(word_cnt), .drop_cycles(drop_cycles)
    );

    // ==================================================
    // Helpers
    // ==================================================
    task automatic fail_timeout(input string what);
        $display("Timeout after %0d cycles while waiting for %s", TIMEOUT, what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
            tb_errs++;
        end
    endtask

    // Poll reset on rising edges and return on the next falling edge
    task automatic wait_reset(input logic level, input string what);
        int n;
        n = 0;
        while (fifoIn_rst !== level && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (fifoIn_rst !== level) fail_timeout(what);
        @(negedge clk);
    endtask

    task automatic issue_cmd(input pix_cmd_t c, input int blk);
        cmd       = c;
        cmd_block = blk[`PIX_BLOCK_BITS-1:0];
        @(negedge clk);
        cmd = PIX_CMD_NONE;
    endtask

    task automatic wait_armed();
        int n;
        n = 0;
        while (!DUT.armed_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!DUT.armed_ack) fail_timeout("the capture stage to arm");
    endtask

    task automatic wait_capture(input int start);
        int n;
        n = 0;
        while (capture_cnt == start && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (capture_cnt == start) fail_timeout("capture_done");
    endtask

    // 10 cycles fv low then 16 lines of 4 pixels and 12 blank cycles
    task automatic drive_frame(input bit long_lv);
        pix = '{d: '0, fv: 1'b0, lv: 1'b0};
        repeat (10) @(negedge clk);
        if (long_lv) begin
            for (int k = 0; k < 256; k++) begin
                pix.fv = 1'b1;
                pix.lv = (k < 64);
                pix.d  = (k < 64) ? 12'($urandom) : 12'h000;
                @(negedge clk);
            end
        end else begin
            for (int line = 0; line < 16; line++) begin
                for (int k = 0; k < 16; k++) begin
                    pix.fv = 1'b1;
                    pix.lv = (k < 4);
                    pix.d  = (k < 4) ? 12'($urandom) : 12'h000;
                    @(negedge clk);
                end
            end
        end
        pix = '{d: '0, fv: 1'b0, lv: 1'b0};
        @(negedge clk);
    endtask

    task automatic run_capture(input int blk);
        int start;
        start = capture_cnt;
        issue_cmd(PIX_CMD_CAPTURE, blk);
        wait_armed();
        drive_frame(1'b0);
        wait_capture(start);
    endtask

    task automatic run_readout(input int blk, input bit random_trig);
        int start_done;
        int start_started;
        int n;
        start_done    = done_cnt;
        start_started = started_cnt;
        issue_cmd(PIX_CMD_READOUT, blk);
        n = 0;
        while (done_cnt == start_done && n < TIMEOUT) begin
            readout_trigger = random_trig ? (($urandom % 100) < 30) : 1'b1;
            @(negedge clk);
            n++;
        end
        readout_trigger = 1'b0;
        if (done_cnt == start_done) fail_timeout("readout_done");
        // A few idle cycles so that a second done pulse would be counted
        repeat (4) @(negedge clk);
        check_value("readout_done pulses", start_done + 1, done_cnt);
        check_value("status.readout_started pulses", start_started + 1, started_cnt);
        check_value("readout words", `PIX_IMAGE_SIZE, word_cnt);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt + tb_errs == errs_before) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail with %0d errors", tests_run, name,
                     err_cnt + tb_errs - errs_before);
        end
        errs_before = err_cnt + tb_errs;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        int start;
        void'($urandom(32'h5da2579e));
        restart         = 1'b0;
        cmd             = PIX_CMD_NONE;
        cmd_block       = '0;
        pix             = '{d: '0, fv: 1'b0, lv: 1'b0};
        readout_trigger = 1'b0;
        tb_errs         = 0;
        tests_run       = 0;
        tests_failed    = 0;
        errs_before     = 0;

        wait_reset(1'b1, "reset release");

        drops_before = drop_cycles;
        run_capture(0);
        run_readout(0, 1'b0);
        check_value("status.pixel_dropped cycles", drops_before, drop_cycles);
        end_test("capture and readout of block 0");

        run_capture(2);
        run_capture(5);
        run_readout(5, 1'b0);
        run_readout(2, 1'b0);
        end_test("two blocks read in reverse order");

        // Command lands while a frame is already running
        start = capture_cnt;
        fork
            drive_frame(1'b0);
            begin
                repeat (40) @(negedge clk);
                issue_cmd(PIX_CMD_CAPTURE, 3);
            end
        join
        drive_frame(1'b0);
        wait_capture(start);
        run_readout(3, 1'b0);
        end_test("capture command in mid frame");

        run_readout(0, 1'b1);
        end_test("readout with random back-pressure");

        issue_cmd(PIX_CMD_CAPTURE, 6);
        wait_armed();
        drive_frame(1'b1);
        check_value("status.pixel_dropped", 1, status.pixel_dropped);
        run_capture(6);
        check_value("status.pixel_dropped", 0, status.pixel_dropped);
        run_readout(6, 1'b0);
        end_test("overflow sets and next capture clears pixel_dropped");

        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        wait_reset(1'b0, "second reset assertion");
        wait_reset(1'b1, "second reset release");
        run_capture(7);
        run_readout(7, 1'b0);
        end_test("capture right after reset");

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, err_cnt + tb_errs);
        if (tests_failed == 0 && err_cnt + tb_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- pix_checker.sv
`include "pix_cfg.svh"

module pix_checker
    import pix_data_pkg::*;
    import pix_ctrl_pkg::*;
(
    input  logic                       clk,
    input  logic                       fifoIn_rst,
    input  pix_cmd_t                   cmd,
    input  logic [`PIX_BLOCK_BITS-1:0] cmd_block,
    input  pix_in_t                    pix,
    input  pix_status_t                status,
    input  logic                       readout_ready,
    input  logic                       readout_trigger,
    input  mem_word_t                  readout_data,
    input  logic                       readout_done,
    output int                         err_cnt,
    output int                         capture_cnt,
    output int                         started_cnt,
    output int                         done_cnt,
    output int                         word_cnt,
    output int                         drop_cycles
);
    localparam int LOG_LEN = 2048;

    // Sensor samples per block since its last capture command
    pix_in_t                    log_mem [`PIX_BLOCK_COUNT][LOG_LEN];
    int                         log_len [`PIX_BLOCK_COUNT];
    logic                       recording;
    logic                       reading;
    logic                       rst_q;
    logic [`PIX_BLOCK_BITS-1:0] rec_block;
    logic [`PIX_BLOCK_BITS-1:0] rd_block;
    mem_word_t                  exp_word;

    // Word idx of a block is the idx-th lv sample from the first fv rise on
    function automatic mem_word_t expected_image(input int blk, input int idx);
        pix_in_t s;
        logic    prev_fv;
        logic    in_frame;
        int      hits;
        prev_fv  = 1'b1;
        in_frame = 1'b0;
        hits     = 0;
        for (int i = 0; i < log_len[blk]; i++) begin
            s = log_mem[blk][i];
            if (!in_frame && !prev_fv && s.fv) begin
                in_frame = 1'b1;
            end
            if (in_frame && s.lv) begin
                if (hits == idx) begin
                    return {4'h0, s.d};
                end
                hits++;
            end
            prev_fv = s.fv;
        end
        return 'x;
    endfunction

    initial begin
        err_cnt     = 0;
        capture_cnt = 0;
        started_cnt = 0;
        done_cnt    = 0;
        word_cnt    = 0;
        drop_cycles = 0;
        recording   = 1'b0;
        reading     = 1'b0;
        rst_q       = 1'b0;
        for (int b = 0; b < `PIX_BLOCK_COUNT; b++) begin
            log_len[b] = 0;
        end
    end

    always @(posedge clk) begin
        rst_q <= fifoIn_rst;
        if (!fifoIn_rst) begin
            recording <= 1'b0;
            reading   <= 1'b0;
        end else begin
            // ==================================================
            // Outputs right after reset
            // ==================================================
            if (!rst_q && (status !== '0 || readout_ready !== 1'b0 || readout_done !== 1'b0)) begin
                $display("** Error at %0t: %s expected %b %b %b actual %b %b %b", $time,
                         "status readout_ready readout_done after reset", 3'b000, 1'b0, 1'b0,
                         status, readout_ready, readout_done);
                err_cnt <= err_cnt + 1;
            end

            // Sample log for the reference image
            if (cmd == PIX_CMD_CAPTURE) begin
                rec_block          <= cmd_block;
                log_len[cmd_block] <= 0;
                recording          <= 1'b1;
            end else if (status.capture_done) begin
                recording <= 1'b0;
            end else if (recording && log_len[rec_block] < LOG_LEN) begin
                log_mem[rec_block][log_len[rec_block]] <= pix;
                log_len[rec_block]                     <= log_len[rec_block] + 1;
            end

            if (cmd == PIX_CMD_READOUT) begin
                rd_block <= cmd_block;
                reading  <= 1'b1;
                word_cnt <= 0;
            end

            // ==================================================
            // Readout words against the reference
            // ==================================================
            if (readout_ready && readout_trigger) begin
                if (!reading || word_cnt >= `PIX_IMAGE_SIZE) begin
                    $display("Readout word accepted at %0t with no word left to read", $time);
                    err_cnt <= err_cnt + 1;
                end else begin
                    exp_word = expected_image(rd_block, word_cnt);
                    if (readout_data !== exp_word) begin
                        $display("** Error at %0t: readout_data word %0d expected %h actual %h",
                                 $time, word_cnt, exp_word, readout_data);
                        err_cnt <= err_cnt + 1;
                    end
                    word_cnt <= word_cnt + 1;
                end
            end

            if (readout_done) begin
                if (!reading || word_cnt != `PIX_IMAGE_SIZE) begin
                    $display("readout_done at %0t came after %0d words or outside a readout",
                             $time, word_cnt);
                    err_cnt <= err_cnt + 1;
                end
                reading  <= 1'b0;
                done_cnt <= done_cnt + 1;
            end

            if (status.capture_done) begin
                capture_cnt <= capture_cnt + 1;
            end
            if (status.readout_started) begin
                started_cnt <= started_cnt + 1;
            end
            if (status.pixel_dropped) begin
                drop_cycles <= drop_cycles + 1;
            end
        end
    end

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic fifoIn_rst,
    input  logic restart
);
    // Period 40, low phase first
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset low for 3 cycles at start, again on each restart request
    initial begin
        fifoIn_rst = 1'b0;
        repeat (3) @(negedge clk);
        fifoIn_rst = 1'b1;
        forever begin
            @(posedge restart);
            @(negedge clk);
            fifoIn_rst = 1'b0;
            repeat (3) @(negedge clk);
            fifoIn_rst = 1'b1;
        end
    end

endmodule

//--- pix_controller.sv
`include "pix_cfg.svh"

module pix_controller
    import pix_data_pkg::*;
    import pix_ctrl_pkg::*;
(
    input  logic                       clk,
    input  logic                       fifoIn_rst,
    input  pix_cmd_t                   cmd,
    input  logic [`PIX_BLOCK_BITS-1:0] cmd_block,
    input  pix_in_t                    pix,
    output pix_status_t                status,
    output logic                       readout_ready,
    input  logic                       readout_trigger,
    output mem_word_t                  readout_data,
    output logic                       readout_done
);
    localparam int CNT_BITS = $clog2(`PIX_IMAGE_SIZE);

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_CAP_OPEN,
        CTRL_CAP_WAIT,
        CTRL_CAP_ARM,
        CTRL_CAP_RUN,
        CTRL_RD_OPEN,
        CTRL_RD_WAIT
    } ctrl_state_t;

    ctrl_state_t                state;
    logic [`PIX_BLOCK_BITS-1:0] block_q;
    mem_cmd_t                   mem_cmd;
    logic                       arm;
    logic                       armed_ack;
    logic                       pixel_dropped;
    logic                       capture_done;
    logic                       readout_started;
    logic [CNT_BITS-1:0]        word_cnt;

    logic      in_w_ready;
    logic      in_w_trigger;
    pix_word_t in_w_data;
    logic      in_flush;
    logic      in_r_ready;
    logic      in_r_trigger;
    pix_word_t in_r_data;

    logic      mem_write_ready;
    logic      wr_trig;
    mem_word_t wr_data;
    logic      mem_write_done;
    logic      mem_read_ready;
    mem_word_t mem_read_data;
    logic      out_w_ready;
    logic      out_flush;

    // ==================================================
    // Datapath blocks
    // ==================================================
    frame_capture u_capture (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .arm(arm), .armed_ack(armed_ack), .pix(pix),
        .fifo_w_ready(in_w_ready), .fifo_w_trigger(in_w_trigger), .fifo_w_data(in_w_data),
        .fifo_flush(in_flush), .pixel_dropped(pixel_dropped)
    );

    sync_fifo #(.payload_t(pix_word_t), .DEPTH(`PIX_FIFO_DEPTH)) fifo_in (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .flush(in_flush),
        .w_ready(in_w_ready), .w_trigger(in_w_trigger), .w_data(in_w_data),
        .r_ready(in_r_ready), .r_trigger(in_r_trigger), .r_data(in_r_data)
    );

    // Read strobe follows fifo_out space so back-pressure stalls the memory
    frame_mem_ctrl u_mem (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .cmd(mem_cmd),
        .write_ready(mem_write_ready), .write_trigger(wr_trig), .write_data(wr_data),
        .write_done(mem_write_done), .read_ready(mem_read_ready), .read_trigger(out_w_ready),
        .read_data(mem_read_data), .read_done()
    );

    sync_fifo #(.payload_t(mem_word_t), .DEPTH(`PIX_FIFO_DEPTH)) fifo_out (
        .clk(clk), .fifoIn_rst(fifoIn_rst), .flush(out_flush),
        .w_ready(out_w_ready), .w_trigger(mem_read_ready), .w_data(mem_read_data),
        .r_ready(readout_ready), .r_trigger(readout_trigger), .r_data(readout_data)
    );

    // Pull a pixel when the held write word is empty or leaving this cycle
    assign in_r_trigger = (state == CTRL_CAP_RUN) && (!wr_trig || mem_write_ready);

    assign status = '{capture_done: capture_done, pixel_dropped: pixel_dropped,
                      readout_started: readout_started};

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state           <= CTRL_IDLE;
            block_q         <= '0;
            mem_cmd         <= '{op: MEM_OP_NONE, block: '0};
            arm             <= 1'b0;
            wr_trig         <= 1'b0;
            out_flush       <= 1'b0;
            capture_done    <= 1'b0;
            readout_started <= 1'b0;
        end else begin
            mem_cmd.op      <= MEM_OP_NONE;
            arm             <= 1'b0;
            out_flush       <= 1'b0;
            capture_done    <= 1'b0;
            readout_started <= 1'b0;
            case (state)
                CTRL_CAP_OPEN: begin
                    mem_cmd <= '{op: MEM_OP_WRITE, block: block_q};
                    state   <= CTRL_CAP_WAIT;
                end
                // Memory must have taken the command and finished its init
                CTRL_CAP_WAIT: begin
                    if (mem_cmd.op == MEM_OP_NONE && mem_write_ready) begin
                        arm   <= 1'b1;
                        state <= CTRL_CAP_ARM;
                    end
                end
                CTRL_CAP_ARM: if (armed_ack) state <= CTRL_CAP_RUN;
                CTRL_CAP_RUN: begin
                    if (wr_trig && mem_write_ready) begin
                        wr_trig <= 1'b0;
                    end
                    if (in_r_ready && in_r_trigger) begin
                        wr_trig <= 1'b1;
                    end
                    if (mem_write_done) begin
                        capture_done <= 1'b1;
                        state        <= CTRL_IDLE;
                    end
                end
                CTRL_RD_OPEN: begin
                    mem_cmd   <= '{op: MEM_OP_READ, block: block_q};
                    out_flush <= 1'b1;
                    state     <= CTRL_RD_WAIT;
                end
                CTRL_RD_WAIT: begin
                    if (mem_cmd.op == MEM_OP_NONE && !out_flush) begin
                        readout_started <= 1'b1;
                        state           <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase

            // Any new command restarts the controller
            if (cmd == PIX_CMD_CAPTURE || cmd == PIX_CMD_READOUT) begin
                block_q <= cmd_block;
                wr_trig <= 1'b0;
                state   <= (cmd == PIX_CMD_CAPTURE) ? CTRL_CAP_OPEN : CTRL_RD_OPEN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_r_ready && in_r_trigger) begin
            wr_data <= mem_word_t'(in_r_data);
        end
    end

    // Readout word counter, done pulses the cycle after the last word
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            word_cnt     <= '0;
            readout_done <= 1'b0;
        end else begin
            readout_done <= 1'b0;
            if (state == CTRL_RD_OPEN) begin
                word_cnt <= '0;
            end else if (readout_ready && readout_trigger) begin
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == CNT_BITS'(`PIX_IMAGE_SIZE - 1)) begin
                    readout_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- frame_capture.sv
module frame_capture
    import pix_data_pkg::*;
(
    input  logic      clk,
    input  logic      fifoIn_rst,
    input  logic      arm,
    output logic      armed_ack,
    input  pix_in_t   pix,
    input  logic      fifo_w_ready,
    output logic      fifo_w_trigger,
    output pix_word_t fifo_w_data,
    output logic      fifo_flush,
    output logic      pixel_dropped
);
    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_FLUSH,
        CAP_ACK,
        CAP_WAIT_LOW,
        CAP_WAIT_HIGH,
        CAP_IN_FRAME
    } cap_state_t;

    cap_state_t state;
    pix_in_t    pix_q;

    // Sensor sample register
    always_ff @(posedge clk) begin
        pix_q <= pix;
    end

    assign fifo_flush  = (state == CAP_FLUSH);
    assign armed_ack   = (state == CAP_ACK);
    assign fifo_w_data = pix_q.d;

    // The sample that shows frame-valid rising is already part of the frame
    assign fifo_w_trigger = pix_q.fv && pix_q.lv &&
                            ((state == CAP_WAIT_HIGH) || (state == CAP_IN_FRAME));

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state         <= CAP_IDLE;
            pixel_dropped <= 1'b0;
        end else begin
            if (arm) begin
                state <= CAP_FLUSH;
            end else begin
                case (state)
                    CAP_FLUSH:     state <= CAP_ACK;
                    CAP_ACK:       state <= CAP_WAIT_LOW;
                    // Skip the rest of a frame already in flight
                    CAP_WAIT_LOW:  if (!pix_q.fv) state <= CAP_WAIT_HIGH;
                    CAP_WAIT_HIGH: if (pix_q.fv) state <= CAP_IN_FRAME;
                    CAP_IN_FRAME:  if (!pix_q.fv) state <= CAP_IDLE;
                    default:       state <= CAP_IDLE;
                endcase
            end

            // Sticky until the next arm
            if (arm) begin
                pixel_dropped <= 1'b0;
            end else if (fifo_w_trigger && !fifo_w_ready) begin
                pixel_dropped <= 1'b1;
            end
        end
    end

endmodule

//--- frame_mem_ctrl.sv
`include "pix_cfg.svh"

module frame_mem_ctrl
    import pix_data_pkg::*;
    import pix_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      fifoIn_rst,
    input  mem_cmd_t  cmd,
    output logic      write_ready,
    input  logic      write_trigger,
    input  mem_word_t write_data,
    output logic      write_done,
    output logic      read_ready,
    input  logic      read_trigger,
    output mem_word_t read_data,
    output logic      read_done
);
    localparam int WORD_BITS = $clog2(`PIX_IMAGE_SIZE);
    localparam int INIT_BITS = $clog2(`MEM_INIT_CYCLES + 1);
    localparam int REF_BITS  = $clog2(`MEM_REFRESH_INTERVAL);
    localparam logic [WORD_BITS-1:0] LAST_WORD = WORD_BITS'(`PIX_IMAGE_SIZE - 1);

    mem_word_t mem [`PIX_BLOCK_COUNT * `PIX_IMAGE_SIZE];

    logic [INIT_BITS-1:0]       init_cnt;
    logic                       init_done;
    logic [REF_BITS-1:0]        ref_cnt;
    logic                       refreshing;
    logic                       busy;
    mem_op_t                    op;
    logic [`PIX_BLOCK_BITS-1:0] block;
    logic [WORD_BITS-1:0]       addr;
    logic                       rd_valid;
    logic                       fetch_done;
    logic                       write_fire;
    logic                       read_fire;
    logic                       fetch;

    // ==================================================
    // Init delay and refresh windows
    // ==================================================
    assign init_done  = (init_cnt == INIT_BITS'(`MEM_INIT_CYCLES));
    assign refreshing = (ref_cnt < REF_BITS'(`MEM_REFRESH_CYCLES));
    assign busy       = !init_done || refreshing;

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            init_cnt <= '0;
            ref_cnt  <= '0;
        end else begin
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
            end
            // Free running, refresh never stops
            ref_cnt <= (ref_cnt == REF_BITS'(`MEM_REFRESH_INTERVAL - 1)) ? '0
                                                                          : ref_cnt + 1'b1;
        end
    end

    // ==================================================
    // Block access
    // ==================================================
    assign write_ready = !busy && (op == MEM_OP_WRITE);
    assign read_ready  = !busy && (op == MEM_OP_READ) && rd_valid;
    assign write_fire  = write_ready && write_trigger;
    assign read_fire   = read_ready && read_trigger;

    // Prefetch the next word when the output register is empty or being taken
    assign fetch = !busy && (op == MEM_OP_READ) && !fetch_done && (!rd_valid || read_fire);

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            op         <= MEM_OP_NONE;
            block      <= '0;
            addr       <= '0;
            rd_valid   <= 1'b0;
            fetch_done <= 1'b0;
            write_done <= 1'b0;
            read_done  <= 1'b0;
        end else begin
            write_done <= 1'b0;
            read_done  <= 1'b0;
            if (cmd.op != MEM_OP_NONE) begin
                // New command aborts whatever was open
                op         <= cmd.op;
                block      <= cmd.block;
                addr       <= '0;
                rd_valid   <= 1'b0;
                fetch_done <= 1'b0;
            end else if (write_fire) begin
                addr <= addr + 1'b1;
                if (addr == LAST_WORD) begin
                    write_done <= 1'b1;
                    op         <= MEM_OP_NONE;
                end
            end else if (op == MEM_OP_READ) begin
                if (fetch) begin
                    addr     <= addr + 1'b1;
                    rd_valid <= 1'b1;
                    if (addr == LAST_WORD) begin
                        fetch_done <= 1'b1;
                    end
                end else if (read_fire) begin
                    rd_valid <= 1'b0;
                end
                // Last word leaves the output register
                if (read_fire && fetch_done) begin
                    read_done <= 1'b1;
                    op        <= MEM_OP_NONE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_fire) begin
            mem[{block, addr}] <= write_data;
        end
        if (fetch) begin
            read_data <= mem[{block, addr}];
        end
    end

endmodule

//--- sync_fifo.sv
module sync_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     fifoIn_rst,
    input  logic     flush,
    output logic     w_ready,
    input  logic     w_trigger,
    input  payload_t w_data,
    output logic     r_ready,
    input  logic     r_trigger,
    output payload_t r_data
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_write;
    logic                do_read;

    // Wrap at DEPTH so any depth works, not only powers of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign w_ready  = (count != CNT_BITS'(DEPTH));
    assign r_ready  = (count != '0);
    assign r_data   = mem[rd_ptr];
    assign do_write = w_ready && w_trigger;
    assign do_read  = r_ready && r_trigger;

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= w_data;
        end
    end

endmodule

//--- pix_ctrl_pkg.sv
`include "pix_cfg.svh"

package pix_ctrl_pkg;

    // Command strobe into the top level
    typedef enum logic [1:0] {
        PIX_CMD_NONE    = 2'b00,
        PIX_CMD_CAPTURE = 2'b01,
        PIX_CMD_READOUT = 2'b10
    } pix_cmd_t;

    // Operation opened on the frame memory
    typedef enum logic [1:0] {
        MEM_OP_NONE  = 2'b00,
        MEM_OP_WRITE = 2'b01,
        MEM_OP_READ  = 2'b10
    } mem_op_t;

    typedef struct packed {
        mem_op_t                    op;
        logic [`PIX_BLOCK_BITS-1:0] block;
    } mem_cmd_t;

    // capture_done and readout_started are one-cycle pulses
    typedef struct packed {
        logic capture_done;
        logic pixel_dropped;
        logic readout_started;
    } pix_status_t;

endpackage

//--- pix_data_pkg.sv
package pix_data_pkg;

    // One 12-bit sample from the sensor data bus
    typedef logic [11:0] pix_word_t;

    // Frame memory word
    // A pixel is stored in the low 12 bits with the top bits zero
    typedef logic [15:0] mem_word_t;

    // Sensor sample as seen on each clk
    typedef struct packed {
        pix_word_t d;
        logic      fv;
        logic      lv;
    } pix_in_t;

endpackage

//--- pix_cfg.svh
`ifndef PIX_CFG_SVH
`define PIX_CFG_SVH

// ==================================================
// Image geometry
// ==================================================
// Words per frame memory block, one per pixel
`define PIX_IMAGE_SIZE 64
`define PIX_BLOCK_COUNT 8
`define PIX_BLOCK_BITS 3

// Entries in each of the capture and readout FIFOs
`define PIX_FIFO_DEPTH 4

// ==================================================
// Frame memory timing
// ==================================================
// Cycles after reset before the array accepts any access
`define MEM_INIT_CYCLES 100

// Refresh window repeats every interval and stalls for this many cycles
`define MEM_REFRESH_INTERVAL 32
`define MEM_REFRESH_CYCLES 8

`endif
